// File: dv/mont_mult_tb.sv
// ==========================================================================
// Directed testbench for the P = 65521 Montgomery multiplier. Expected
// results come from a 64-bit model with R^-1 mod P held locally
// ==========================================================================

`timescale 1ns/10ps

module mont_mult_tb
  import mont_params_pkg::*;
  import mont_stream_pkg::*;
();

  localparam logic [63:0] RINV = 64'd64429;
  localparam logic [DAT_BITS-1:0] R_MOD_P = 16'd60;
  localparam logic [31:0] SEED = 32'hed18_35a8;
  localparam int LAT = 4;
  localparam int N_DIRECTED = 4;
  localparam int N_RANDOM = 200;
  localparam int N_BP = 150;
  localparam int N_FINAL = 16;
  localparam int WATCHDOG_CYCLES = 20 * (N_DIRECTED + N_RANDOM + N_BP + N_FINAL) + 1000;

  logic      i_clk = 1'b0;
  logic      i_rst;
  mont_in_t  i_in;
  logic      i_in_val;
  logic      o_in_rdy;
  mont_out_t o_out;
  logic      o_out_val;
  logic      i_out_rdy;

  mont_out_t           exp_q[$];
  logic [31:0]         op_seed;
  logic [31:0]         rdy_seed;
  logic [CTL_BITS-1:0] tag;
  logic                mon_en;
  logic                bp_en;
  logic                full_seen;
  int                  cyc = 0;

  mont_mult_top DUT (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_in      (i_in),
    .i_in_val  (i_in_val),
    .o_in_rdy  (o_in_rdy),
    .o_out     (o_out),
    .o_out_val (o_out_val),
    .i_out_rdy (i_out_rdy)
  );

  always #5 i_clk = ~i_clk;

  always @(posedge i_clk) begin
    cyc <= cyc + 1;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_out(input mont_out_t exp, input mont_out_t act);
    if (act.ctl !== exp.ctl || act.r !== exp.r) begin
      fail_run($sformatf("error at %0t: result tag %0d r %0d, expected tag %0d r %0d",
                         $time, act.ctl, act.r, exp.ctl, exp.r));
    end
  endtask

  task automatic check_level(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      fail_run($sformatf("error at %0t: %s is %b, expected %b", $time, what, act, exp));
    end
  endtask

  task automatic check_count(input string what, input int exp, input int act);
    if (act != exp) begin
      fail_run($sformatf("error at %0t: %s is %0d, expected %0d", $time, what, act, exp));
    end
  endtask

  task automatic check_idle();
    check_level("o_out_val after reset", 1'b0, o_out_val);
    check_level("o_in_rdy after reset", 1'b1, o_in_rdy);
  endtask

  // a * b * R^-1 mod P, straight from the definition
  function automatic mont_out_t model_result(input mont_in_t item);
    logic [63:0] acc;
    mont_out_t   res;
    acc = (64'(item.a) * 64'(item.b)) % 64'(P);
    acc = (acc * RINV) % 64'(P);
    res.ctl = item.ctl;
    res.r   = acc[DAT_BITS-1:0];
    return res;
  endfunction

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [DAT_BITS-1:0] rand_operand();
    logic [31:0] v;
    op_seed = lcg_step(op_seed);
    v = {8'd0, op_seed[31:8]} % {16'd0, P};
    return v[DAT_BITS-1:0];
  endfunction

  function automatic mont_in_t make_item(input logic [DAT_BITS-1:0] a,
                                         input logic [DAT_BITS-1:0] b);
    mont_in_t item;
    item.ctl = tag;
    item.a   = a;
    item.b   = b;
    tag = tag + 1'b1;
    return item;
  endfunction

  // Hold the item until the DUT takes it, return just after that edge
  task automatic send_item(input mont_in_t item);
    logic taken;
    i_in = item;
    i_in_val = 1'b1;
    taken = 1'b0;
    while (!taken) begin
      @(negedge i_clk);
      taken = o_in_rdy;
      @(posedge i_clk);
      #1;
    end
    i_in_val = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(posedge i_clk);
      #1;
    end
  endtask

  // Transfers are seen half a cycle ahead of the edge that makes them
  always @(negedge i_clk) begin
    mont_out_t exp_item;
    if (mon_en) begin
      // Input stalls exactly when all four slots hold items and the output waits
      check_level("o_in_rdy", !(exp_q.size() == LAT && !i_out_rdy), o_in_rdy);
      if (!o_in_rdy) full_seen = 1'b1;
      if (o_out_val && i_out_rdy) begin
        if (exp_q.size() == 0) begin
          fail_run("an output came out with no item outstanding");
        end else begin
          exp_item = exp_q.pop_front();
          check_out(exp_item, o_out);
        end
      end
      if (i_in_val && o_in_rdy) exp_q.push_back(model_result(i_in));
    end
  end

  always @(posedge i_clk) begin
    #1;
    if (bp_en) begin
      rdy_seed = lcg_step(rdy_seed);
      i_out_rdy = (rdy_seed[31:29] >= 3'd5);
    end
  end

  task automatic run_single(input mont_in_t item, input mont_out_t exp);
    int lat;
    wait_drain();
    send_item(item);
    lat = 1;
    while (!o_out_val) begin
      @(posedge i_clk);
      #1;
      lat++;
    end
    check_count("latency in cycles", LAT, lat);
    check_out(exp, o_out);
  endtask

  task automatic test_reset_idle();
    check_idle();
    repeat (10) begin
      @(posedge i_clk);
      #1;
      check_level("o_out_val with no input", 1'b0, o_out_val);
    end
  endtask

  task automatic test_directed();
    mont_in_t  item;
    mont_out_t exp;
    logic [DAT_BITS-1:0] a;
    a = rand_operand();
    item = make_item(16'd0, a);
    exp.ctl = item.ctl;
    exp.r = '0;
    run_single(item, exp);
    // b = R mod P cancels the R^-1
    a = rand_operand();
    item = make_item(a, R_MOD_P);
    exp.ctl = item.ctl;
    exp.r = a;
    run_single(item, exp);
    item = make_item(P - 1'b1, P - 1'b1);
    run_single(item, model_result(item));
    item = make_item(16'd1, 16'd1);
    run_single(item, model_result(item));
  endtask

  task automatic test_random_stream();
    int start;
    wait_drain();
    start = cyc;
    repeat (N_RANDOM) send_item(make_item(rand_operand(), rand_operand()));
    check_count("cycles for back-to-back stream", N_RANDOM, cyc - start);
    wait_drain();
  endtask

  task automatic test_back_pressure();
    full_seen = 1'b0;
    bp_en = 1'b1;
    repeat (N_BP) send_item(make_item(rand_operand(), rand_operand()));
    wait_drain();
    bp_en = 1'b0;
    @(posedge i_clk);
    #1;
    i_out_rdy = 1'b1;
    check_level("pipeline filled under back-pressure", 1'b1, full_seen);
  endtask

  task automatic test_final_sub();
    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 4; j++) begin
        send_item(make_item(P - 16'(1 + i), P - 16'(1 + 4 * j)));
      end
    end
    wait_drain();
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge i_clk);
    fail_run("timeout: the pipeline stalled before all items came out");
  end

  initial begin
    i_rst = 1'b1;
    i_in = '0;
    i_in_val = 1'b0;
    i_out_rdy = 1'b1;
    mon_en = 1'b0;
    bp_en = 1'b0;
    full_seen = 1'b0;
    tag = '0;
    op_seed = SEED;
    rdy_seed = ~SEED;
    repeat (2) @(posedge i_clk);
    #1;
    i_rst = 1'b0;
    mon_en = 1'b1;
    test_reset_idle();
    test_directed();
    test_random_stream();
    test_back_pressure();
    test_final_sub();
    if (exp_q.size() == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      fail_run("items were still outstanding at the end of the tests");
    end
  end

endmodule

// File: mont_mult_top.f
src/mont_params_pkg.sv
src/mont_stream_pkg.sv
src/mont_product_stage.sv
src/mont_quotient_stage.sv
src/mont_reduce_stage.sv
src/mont_final_sub_stage.sv
src/mont_mult_top.sv
dv/mont_mult_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the Montgomery multiplier testbench with Verilator.
# A log line with the fail message marks the run as failed.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f mont_mult_top.f \
  --top-module mont_mult_tb -o mont_mult_sim || { echo "build failed"; exit 1; }
./obj_dir/mont_mult_sim > sim.log 2>&1
cat sim.log
grep -q "Done: errors found" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "Done: no errors" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation PASSED"
exit 0

// File: src/mont_final_sub_stage.sv
// =========================================================================
// One conditional subtract of P. Relies on u < 2P from the reduce stage,
// so the output is always below P
// =========================================================================

`timescale 1ns/10ps

module mont_final_sub_stage
  import mont_params_pkg::*;
  import mont_stream_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst,
  input  mont_red_t i_red,
  input  logic      i_val,
  output logic      o_rdy,
  output mont_out_t o_out,
  output logic      o_val,
  input  logic      i_rdy
);

  logic [DAT_BITS:0]   diff;
  logic [DAT_BITS-1:0] r_nxt;

  always_comb begin
    diff = i_red.u - {1'b0, P};
    // Top bit of diff is the borrow, set only when u < P
    r_nxt = diff[DAT_BITS] ? i_red.u[DAT_BITS-1:0] : diff[DAT_BITS-1:0];
  end

  assign o_rdy = ~o_val | i_rdy;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_val <= 1'b0;
    end else if (o_rdy) begin
      o_val <= i_val;
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_rdy && i_val) begin
      o_out.ctl <= i_red.ctl;
      o_out.r   <= r_nxt;
    end
  end

endmodule

// File: src/mont_mult_top.sv
// =========================================================================
// Montgomery multiplier for P = 65521, R = 2^18. Returns a*b*R^-1 mod P.
// Four stage valid/ready pipeline, results in input order with tag kept
// =========================================================================

`timescale 1ns/10ps

module mont_mult_top
  import mont_stream_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst,
  input  mont_in_t  i_in,
  input  logic      i_in_val,
  output logic      o_in_rdy,
  output mont_out_t o_out,
  output logic      o_out_val,
  input  logic      i_out_rdy
);

  // Product to quotient link
  mont_prod_t prod;
  logic       prod_val;
  logic       prod_rdy;

  // Quotient to reduce link
  mont_quot_t quot;
  logic       quot_val;
  logic       quot_rdy;

  // Reduce to final subtract link
  mont_red_t  red;
  logic       red_val;
  logic       red_rdy;

  mont_product_stage u_product (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_in   (i_in),
    .i_val  (i_in_val),
    .o_rdy  (o_in_rdy),
    .o_prod (prod),
    .o_val  (prod_val),
    .i_rdy  (prod_rdy)
  );

  mont_quotient_stage u_quotient (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_prod (prod),
    .i_val  (prod_val),
    .o_rdy  (prod_rdy),
    .o_quot (quot),
    .o_val  (quot_val),
    .i_rdy  (quot_rdy)
  );

  mont_reduce_stage u_reduce (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_quot (quot),
    .i_val  (quot_val),
    .o_rdy  (quot_rdy),
    .o_red  (red),
    .o_val  (red_val),
    .i_rdy  (red_rdy)
  );

  // Last slot drives the output port directly
  mont_final_sub_stage u_final_sub (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_red  (red),
    .i_val  (red_val),
    .o_rdy  (red_rdy),
    .o_out  (o_out),
    .o_val  (o_out_val),
    .i_rdy  (i_out_rdy)
  );

endmodule

// File: src/mont_params_pkg.sv
// =========================================================================
// Constants hold for the single modulus P = 65521 only. P and FACTOR must
// change together. Inputs are expected in Montgomery form, below P
// =========================================================================

package mont_params_pkg;

  // Operand and result width
  localparam int DAT_BITS = 16;

  // Radix R = 2^REDUCE_BITS, two bits above DAT_BITS so u stays below 2P
  localparam int REDUCE_BITS = DAT_BITS + 2;

  // Tag carried alongside each operand pair
  localparam int CTL_BITS = 8;

  // The odd modulus, 2^16 - 15
  localparam logic [DAT_BITS-1:0] P = 16'hfff1;

  // -P^-1 mod 2^18, so that P * FACTOR == -1 mod R
  localparam logic [REDUCE_BITS-1:0] FACTOR = 18'h3eeef;

  // Low bits of T that feed the quotient multiply
  localparam int MASK_BITS = REDUCE_BITS;

endpackage

// File: src/mont_product_stage.sv
// =========================================================================
// Input slot of the pipeline. Holds one item. Ready is combinational from
// the downstream ready
// =========================================================================

`timescale 1ns/10ps

module mont_product_stage
  import mont_params_pkg::*;
  import mont_stream_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_rst,
  input  mont_in_t   i_in,
  input  logic       i_val,
  output logic       o_rdy,
  output mont_prod_t o_prod,
  output logic       o_val,
  input  logic       i_rdy
);

  logic [2*DAT_BITS-1:0] t_nxt;

  // 16 x 16 full product
  always_comb begin
    t_nxt = i_in.a * i_in.b;
  end

  // Slot free, or its item leaves this cycle
  assign o_rdy = ~o_val | i_rdy;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_val <= 1'b0;
    end else if (o_rdy) begin
      o_val <= i_val;
    end
  end

  // Payload only loads on a real transfer
  always_ff @(posedge i_clk) begin
    if (o_rdy && i_val) begin
      o_prod.ctl <= i_in.ctl;
      o_prod.t   <= t_nxt;
    end
  end

endmodule

// File: src/mont_quotient_stage.sv
// =========================================================================
// Montgomery quotient m = (T mod R) * FACTOR mod R. T passes through
// unchanged for the reduce stage
// =========================================================================

`timescale 1ns/10ps

module mont_quotient_stage
  import mont_params_pkg::*;
  import mont_stream_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_rst,
  input  mont_prod_t i_prod,
  input  logic       i_val,
  output logic       o_rdy,
  output mont_quot_t o_quot,
  output logic       o_val,
  input  logic       i_rdy
);

  logic [REDUCE_BITS-1:0] m_nxt;

  // Only the low radix bits matter, product truncated to 18 bits
  always_comb begin
    m_nxt = i_prod.t[MASK_BITS-1:0] * FACTOR;
  end

  assign o_rdy = ~o_val | i_rdy;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_val <= 1'b0;
    end else if (o_rdy) begin
      o_val <= i_val;
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_rdy && i_val) begin
      o_quot.ctl <= i_prod.ctl;
      o_quot.t   <= i_prod.t;
      o_quot.m   <= m_nxt;
    end
  end

endmodule

// File: src/mont_reduce_stage.sv
// =========================================================================
// Forms T + m * P, whose low 18 bits are zero, and keeps the quotient by R.
// The result u is below 2P when T < P^2
// =========================================================================

`timescale 1ns/10ps

module mont_reduce_stage
  import mont_params_pkg::*;
  import mont_stream_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_rst,
  input  mont_quot_t i_quot,
  input  logic       i_val,
  output logic       o_rdy,
  output mont_red_t  o_red,
  output logic       o_val,
  input  logic       i_rdy
);

  // m * P fits in 34 bits, the sum needs one more
  logic [REDUCE_BITS+DAT_BITS-1:0] mp;
  logic [REDUCE_BITS+DAT_BITS:0]   sum;
  logic [DAT_BITS:0]               u_nxt;

  always_comb begin
    mp    = i_quot.m * P;
    sum   = i_quot.t + mp;
    // Division by R is a plain shift here
    u_nxt = sum[REDUCE_BITS +: DAT_BITS+1];
  end

  assign o_rdy = ~o_val | i_rdy;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_val <= 1'b0;
    end else if (o_rdy) begin
      o_val <= i_val;
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_rdy && i_val) begin
      o_red.ctl <= i_quot.ctl;
      o_red.u   <= u_nxt;
    end
  end

endmodule

// File: src/mont_stream_pkg.sv
// =========================================================================
// Payload types passed between the four multiplier stages. Widths follow
// the constants of the modulus package
// =========================================================================

package mont_stream_pkg;

  import mont_params_pkg::*;

  // Operand pair at the input port, both below P
  typedef struct packed {
    logic [CTL_BITS-1:0] ctl;
    logic [DAT_BITS-1:0] a;
    logic [DAT_BITS-1:0] b;
  } mont_in_t;

  // Full product T = a * b
  typedef struct packed {
    logic [CTL_BITS-1:0]   ctl;
    logic [2*DAT_BITS-1:0] t;
  } mont_prod_t;

  // T plus the quotient m = T * FACTOR mod R
  typedef struct packed {
    logic [CTL_BITS-1:0]    ctl;
    logic [2*DAT_BITS-1:0]  t;
    logic [REDUCE_BITS-1:0] m;
  } mont_quot_t;

  // (T + m * P) / R, one bit wider than P since it may reach 2P - 1
  typedef struct packed {
    logic [CTL_BITS-1:0] ctl;
    logic [DAT_BITS:0]   u;
  } mont_red_t;

  // Fully reduced result
  typedef struct packed {
    logic [CTL_BITS-1:0] ctl;
    logic [DAT_BITS-1:0] r;
  } mont_out_t;

endpackage
